// File: hdl/tcdm_pkg.sv
// shared widths and payloads; the id width must cover NB_CHAN, the bank is one 256-word port
`default_nettype none

package tcdm_pkg;

  // initiator channels sharing the bank
  localparam int unsigned NB_CHAN = 3;
  // the channel index travels as request id
  localparam int unsigned IW = $clog2(NB_CHAN);
  // word address, data and byte-enable widths
  localparam int unsigned AW = 8;
  localparam int unsigned DW = 32;
  localparam int unsigned BW = DW / 8;

  // fifo depths, sw is the free-count width of the response fifo
  localparam int unsigned REQ_DEPTH = 2;
  localparam int unsigned RSP_DEPTH = 4;
  localparam int unsigned SW        = $clog2(RSP_DEPTH + 1);

  // request towards the bank, wen high means read
  typedef struct packed {
    logic [AW-1:0] add;
    logic          wen;
    logic [DW-1:0] data;
    logic [BW-1:0] be;
    logic [IW-1:0] id;
  } req_payload_t;

  // response from the bank with the reflected id
  typedef struct packed {
    logic [DW-1:0] data;
    logic [IW-1:0] id;
  } rsp_payload_t;

endpackage

`default_nettype wire

// File: hdl/tcdm_fifo.sv
// in_ready looks only at occupancy, so a full fifo refuses a push even when popping
`timescale 1ns/100ps
`default_nettype none

module tcdm_fifo
  import tcdm_pkg::*;
#(
  parameter type         payload_t = req_payload_t,
  parameter int unsigned DEPTH     = REQ_DEPTH
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear,
  input  logic                       in_valid,
  input  payload_t                   in_data,
  output logic                       in_ready,
  output logic                       out_valid,
  output payload_t                   out_data,
  input  logic                       out_ready,
  output logic [$clog2(DEPTH+1)-1:0] space
);

  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  payload_t      mem_q [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          push;
  logic          pop;

  // circular pointer step
  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready  = (count_q != CW'(DEPTH));
  assign out_valid = (count_q != '0);
  assign out_data  = mem_q[rd_ptr_q];
  // free slots, read by the id filter as credit
  assign space     = CW'(DEPTH) - count_q;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      // occupancy holds when push and pop meet
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_data;
  end

endmodule

`default_nettype wire

// File: hdl/ooo_arbiter.sv
// combinational grant; forced entries outside 0..NB_CHAN-1 are skipped, responses route by id only
`timescale 1ns/100ps
`default_nettype none

module ooo_arbiter
  import tcdm_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear,
  input  logic                       priority_force,
  input  logic [NB_CHAN-1:0][IW-1:0] prio,
  input  logic [NB_CHAN-1:0]         req,
  input  logic [NB_CHAN-1:0][AW-1:0] add,
  input  logic [NB_CHAN-1:0]         wen,
  input  logic [NB_CHAN-1:0][DW-1:0] data,
  input  logic [NB_CHAN-1:0][BW-1:0] be,
  input  logic [NB_CHAN-1:0]         r_ready,
  output logic [NB_CHAN-1:0]         gnt,
  output logic [NB_CHAN-1:0]         r_valid,
  output logic [DW-1:0]              r_data,
  output logic                       out_req,
  output req_payload_t               out_payload,
  input  logic                       out_ready,
  input  logic                       rsp_valid,
  input  rsp_payload_t               rsp_payload,
  output logic                       rsp_ready
);

  logic [IW-1:0]              rr_q;
  logic [NB_CHAN-1:0][IW-1:0] prio_list;
  logic [IW-1:0]              winner;
  logic                       win_valid;

  // round-robin counter, one step per accepted request of any channel
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (clear) begin
      rr_q <= '0;
    end else if (out_req && out_ready) begin
      // wrap after the last channel
      if (rr_q == IW'(NB_CHAN - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= rr_q + 1'b1;
      end
    end
  end

  // entry k of the list, entry 0 is served first
  for (genvar k = 0; k < NB_CHAN; k++) begin : g_list
    // widen before the add so counter plus k cannot overflow IW bits
    assign prio_list[k] = priority_force ? prio[k]
                                         : IW'((int'(rr_q) + k) % NB_CHAN);
  end

  // first listed channel with a pending req wins
  always_comb begin
    winner    = rr_q;
    win_valid = 1'b0;
    for (int k = 0; k < NB_CHAN; k++) begin
      if (!win_valid && (prio_list[k] < NB_CHAN) && req[prio_list[k]]) begin
        winner    = prio_list[k];
        win_valid = 1'b1;
      end
    end
  end

  // winner fields towards the request fifo
  assign out_req          = win_valid;
  assign out_payload.add  = add[winner];
  assign out_payload.wen  = wen[winner];
  assign out_payload.data = data[winner];
  assign out_payload.be   = be[winner];
  // tag with the channel index so the response finds its way back
  assign out_payload.id   = winner;

  for (genvar c = 0; c < NB_CHAN; c++) begin : g_chan
    // gnt only when the fifo takes the request in this cycle
    assign gnt[c]     = win_valid && (winner == IW'(c)) && out_ready;
    // response decode by id, never by arrival order
    assign r_valid[c] = rsp_valid && (rsp_payload.id == IW'(c));
  end

  // data is shared, r_valid tells which channel owns it
  assign r_data = rsp_payload.data;

  // head of the response fifo waits for its own channel
  assign rsp_ready = (rsp_payload.id < NB_CHAN) ? r_ready[rsp_payload.id] : 1'b0;

endmodule

`default_nettype wire

// File: hdl/r_id_filter.sv
// sits at the zero-latency bank boundary; assumes one-cycle read data and a consumer with no ready
`timescale 1ns/100ps
`default_nettype none

module r_id_filter
  import tcdm_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear,
  input  logic          req_valid,
  input  req_payload_t  req_payload,
  input  logic [SW-1:0] space,
  output logic          req_ready,
  output logic          mem_req,
  output logic [AW-1:0] mem_add,
  output logic          mem_wen,
  output logic [DW-1:0] mem_data,
  output logic [BW-1:0] mem_be,
  input  logic [DW-1:0] mem_rdata,
  output logic          rsp_valid,
  output rsp_payload_t  rsp_payload
);

  logic          inflight_q;
  logic [IW-1:0] id_q;
  logic          credit;

  // a slot must stay for the response already on its way
  assign credit = (space >= SW'(2)) || ((space == SW'(1)) && !inflight_q);

  assign req_ready = credit;
  assign mem_req   = req_valid && credit;
  assign mem_add   = req_payload.add;
  assign mem_wen   = req_payload.wen;
  assign mem_data  = req_payload.data;
  assign mem_be    = req_payload.be;

  // response is due one cycle after every access, reads and writes alike
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) inflight_q <= 1'b0;
    else if (clear) inflight_q <= 1'b0;
    else inflight_q <= mem_req;
  end

  always_ff @(posedge clk_i) begin
    if (mem_req) id_q <= req_payload.id;
  end

  // reflect the id next to the bank data
  assign rsp_valid        = inflight_q;
  assign rsp_payload.data = mem_rdata;
  assign rsp_payload.id   = id_q;

endmodule

`default_nettype wire

// File: hdl/tcdm_bank.sv
// single port, always ready; contents stay undefined until written, rdata holds after a write
`timescale 1ns/100ps
`default_nettype none

module tcdm_bank
  import tcdm_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          mem_req,
  input  logic [AW-1:0] mem_add,
  input  logic          mem_wen,
  input  logic [DW-1:0] mem_data,
  input  logic [BW-1:0] mem_be,
  output logic [DW-1:0] mem_rdata
);

  // 256 words of DW bits
  logic [DW-1:0] mem_q [2**AW];
  logic [DW-1:0] rdata_q;

  // write path, wen low, only the enabled bytes change
  always_ff @(posedge clk_i) begin
    if (mem_req && !mem_wen) begin
      for (int b = 0; b < BW; b++) begin
        if (mem_be[b]) begin
          mem_q[mem_add][8*b +: 8] <= mem_data[8*b +: 8];
        end
      end
    end
  end

  // read path, word registered for the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (mem_req && mem_wen) begin
      rdata_q <= mem_q[mem_add];
    end
  end

  assign mem_rdata = rdata_q;

endmodule

`default_nettype wire

// File: hdl/tcdm_ooo_subsys.sv
// r_data is one bus shared by all channels; only the channel with r_valid high owns it
`timescale 1ns/100ps
`default_nettype none

module tcdm_ooo_subsys
  import tcdm_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear,
  input  logic                       priority_force,
  input  logic [NB_CHAN-1:0][IW-1:0] prio,
  input  logic [NB_CHAN-1:0]         req,
  input  logic [NB_CHAN-1:0][AW-1:0] add,
  input  logic [NB_CHAN-1:0]         wen,
  input  logic [NB_CHAN-1:0][DW-1:0] data,
  input  logic [NB_CHAN-1:0][BW-1:0] be,
  input  logic [NB_CHAN-1:0]         r_ready,
  output logic [NB_CHAN-1:0]         gnt,
  output logic [NB_CHAN-1:0]         r_valid,
  output logic [DW-1:0]              r_data
);

  // arbiter to request fifo
  logic         arb_req;
  logic         arb_ready;
  req_payload_t arb_payload;
  // request fifo to id filter
  logic         flt_valid;
  logic         flt_ready;
  req_payload_t flt_payload;
  // filter and bank
  logic          mem_req;
  logic [AW-1:0] mem_add;
  logic          mem_wen;
  logic [DW-1:0] mem_data;
  logic [BW-1:0] mem_be;
  logic [DW-1:0] mem_rdata;
  // filter to response fifo, credit comes back as the free count
  logic          bank_rsp_valid;
  rsp_payload_t  bank_rsp_payload;
  logic [SW-1:0] rsp_space;
  // response fifo to arbiter
  logic          rsp_valid;
  logic          rsp_ready;
  rsp_payload_t  rsp_payload;

  ooo_arbiter i_arbiter (
    .clk_i, .rst_ni, .clear, .priority_force, .prio,
    .req, .add, .wen, .data, .be, .r_ready,
    .gnt, .r_valid, .r_data,
    .out_req(arb_req), .out_payload(arb_payload), .out_ready(arb_ready),
    .rsp_valid, .rsp_payload, .rsp_ready
  );

  // request fifo, its free count is not needed upstream
  tcdm_fifo #(.payload_t(req_payload_t), .DEPTH(REQ_DEPTH)) i_req_fifo (
    .clk_i, .rst_ni, .clear,
    .in_valid(arb_req), .in_data(arb_payload), .in_ready(arb_ready),
    .out_valid(flt_valid), .out_data(flt_payload), .out_ready(flt_ready),
    .space()
  );

  r_id_filter i_filter (
    .clk_i, .rst_ni, .clear,
    .req_valid(flt_valid), .req_payload(flt_payload), .space(rsp_space),
    .req_ready(flt_ready),
    .mem_req, .mem_add, .mem_wen, .mem_data, .mem_be, .mem_rdata,
    .rsp_valid(bank_rsp_valid), .rsp_payload(bank_rsp_payload)
  );

  tcdm_bank i_bank (
    .clk_i, .rst_ni, .mem_req, .mem_add, .mem_wen, .mem_data, .mem_be, .mem_rdata
  );

  // response fifo, never full on a push thanks to the filter credit
  tcdm_fifo #(.payload_t(rsp_payload_t), .DEPTH(RSP_DEPTH)) i_rsp_fifo (
    .clk_i, .rst_ni, .clear,
    .in_valid(bank_rsp_valid), .in_data(bank_rsp_payload), .in_ready(),
    .out_valid(rsp_valid), .out_data(rsp_payload), .out_ready(rsp_ready),
    .space(rsp_space)
  );

endmodule

`default_nettype wire

// File: bench/tcdm_ooo_asserts.sv
// bound to tcdm_ooo_subsys; holds outside reset only and assumes clear pulses on an idle DUT
`timescale 1ns/100ps
`default_nettype none

module tcdm_ooo_asserts
  import tcdm_pkg::*;
(
  input logic               clk_i,
  input logic               rst_ni,
  input logic [NB_CHAN-1:0] req,
  input logic [NB_CHAN-1:0] gnt,
  input logic [NB_CHAN-1:0] r_valid,
  input logic [NB_CHAN-1:0] r_ready
);

  // one winner per cycle
  gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt))
    else $error("more than one grant in a cycle");

  // no grant without its own request
  gnt_has_req : assert property (@(posedge clk_i) disable iff (!rst_ni) (gnt & ~req) == '0)
    else $error("grant on a channel that does not request");

  // the response head belongs to a single channel
  rvalid_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(r_valid))
    else $error("response offered on more than one channel");

  // a waiting response stays on its channel until taken
  rvalid_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((r_valid & ~r_ready) != '0) |=> (r_valid == $past(r_valid)))
    else $error("pending response moved or vanished");

endmodule

bind tcdm_ooo_subsys tcdm_ooo_asserts i_asserts (
  .clk_i, .rst_ni, .req, .gnt, .r_valid, .r_ready
);

`default_nettype wire

// File: bench/tb_tcdm_ooo_subsys.sv
// needs NB_CHAN=3 and the one-cycle bank; clear follows a full drain, unwritten bytes go unchecked
`timescale 1ns/100ps
`default_nettype none

module tb_tcdm_ooo_subsys
  import tcdm_pkg::*;
();

  // requests per channel in each random test
  localparam int N_PER     = 20;
  localparam int N_CLR     = 3;
  localparam int N_LONE    = 2;
  localparam int TOTAL_REQ = 5 * NB_CHAN * N_PER + N_LONE + NB_CHAN * N_CLR;
  localparam int LIMIT     = 10 * TOTAL_REQ + 200;
  // both fifos full, the filter slot lives inside the response credit
  localparam int MAX_INFLIGHT = REQ_DEPTH + RSP_DEPTH;
  localparam int M_DATA  = 0;
  localparam int M_ROUTE = 1;
  localparam int M_RR    = 2;
  localparam int M_FORCE = 3;
  localparam int M_BP    = 4;
  localparam int M_CLR   = 5;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       clear;
  logic                       priority_force;
  logic [NB_CHAN-1:0][IW-1:0] prio;
  logic [NB_CHAN-1:0]         req;
  logic [NB_CHAN-1:0][AW-1:0] add;
  logic [NB_CHAN-1:0]         wen;
  logic [NB_CHAN-1:0][DW-1:0] data;
  logic [NB_CHAN-1:0][BW-1:0] be;
  logic [NB_CHAN-1:0]         r_ready;
  logic [NB_CHAN-1:0]         gnt;
  logic [NB_CHAN-1:0]         r_valid;
  logic [DW-1:0]              r_data;

  // reference memory, known_m marks bytes written so far
  logic [DW-1:0]   mem_m [2**AW];
  logic [DW-1:0]   known_m [2**AW];
  // expected responses per channel, mask in the upper half
  logic [2*DW-1:0] exp_q [NB_CHAN][$];
  logic [31:0]        lfsr = 32'h7d18_1525;
  logic [NB_CHAN-1:0] accepted;
  logic [NB_CHAN-1:0] pend_q;
  logic               after_clear;
  int    rr_cnt;
  int    mode;
  int    n_chk;
  int    n_err;
  int    n_tests;
  int    cycles;
  int    issue_left [NB_CHAN];
  int    n_acc [NB_CHAN];
  int    n_rsp [NB_CHAN];
  int    hold_cnt [NB_CHAN];
  string test_name;

  tcdm_ooo_subsys i_dut (
    .clk_i, .rst_ni, .clear, .priority_force, .prio,
    .req, .add, .wen, .data, .be, .r_ready,
    .gnt, .r_valid, .r_data
  );

  // galois lfsr, one step per bit handed out
  function automatic logic [31:0] rnd_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    n_chk++;
    if (exp_v !== act_v) begin
      n_err++;
      $display("ERROR %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic flag_failure(input string what);
    n_err++;
    $display("%s: %s", test_name, what);
  endtask

  // sample at the falling edge, the values the next rising edge will act on
  task automatic observe();
    int              ch;
    int              win;
    int              in_flight;
    logic            found;
    logic [2*DW-1:0] e;
    in_flight = 0;
    for (int c = 0; c < NB_CHAN; c++) begin
      in_flight += n_acc[c] - n_rsp[c];
    end
    // expected winner from the model counter or the forced list
    found = 1'b0;
    win   = 0;
    for (int k = 0; k < NB_CHAN; k++) begin
      ch = priority_force ? int'(prio[k]) : (rr_cnt + k) % NB_CHAN;
      if (!found && req[ch]) begin
        win   = ch;
        found = 1'b1;
      end
    end
    if (gnt != '0) begin
      if (in_flight >= MAX_INFLIGHT) begin
        flag_failure("grant given while six requests are already in flight");
      end
      check({test_name, " gnt"}, found ? (32'd1 << win) : 32'd0, 32'(gnt));
      if (after_clear) begin
        check({test_name, " first gnt"}, 32'd1, 32'(gnt));
        after_clear = 1'b0;
      end
    end else if (found && in_flight < REQ_DEPTH) begin
      // request fifo cannot be full with fewer than two in flight
      flag_failure("request pending with room in the request FIFO but nothing granted");
    end
    for (int c = 0; c < NB_CHAN; c++) begin
      if (gnt[c] && req[c]) begin
        accepted[c] = 1'b1;
        n_acc[c]++;
        rr_cnt = (rr_cnt + 1) % NB_CHAN;
        if (wen[c]) begin
          exp_q[c].push_back({known_m[add[c]], mem_m[add[c]]});
        end else begin
          // only the enabled bytes change
          for (int b = 0; b < BW; b++) begin
            if (be[c][b]) begin
              mem_m[add[c]][8*b +: 8]   = data[c][8*b +: 8];
              known_m[add[c]][8*b +: 8] = 8'hff;
            end
          end
          exp_q[c].push_back('0);
        end
      end
    end
    if ($countones(r_valid) > 1) begin
      flag_failure("response offered on more than one channel");
    end
    if ((pend_q != '0) && (r_valid != pend_q)) begin
      flag_failure("a waiting response moved to another channel or vanished");
    end
    pend_q = r_valid & ~r_ready;
    for (int c = 0; c < NB_CHAN; c++) begin
      if (r_valid[c] && r_ready[c]) begin
        n_rsp[c]++;
        if (exp_q[c].size() == 0) begin
          flag_failure($sformatf("channel %0d got a response it never asked for", c));
        end else begin
          e = exp_q[c].pop_front();
          check({test_name, " r_data"}, e[DW-1:0] & e[2*DW-1:DW], r_data & e[2*DW-1:DW]);
        end
      end
    end
  endtask

  // new stimulus at the rising edge
  task automatic drive();
    int   rot;
    logic rev;
    logic go;
    for (int c = 0; c < NB_CHAN; c++) begin
      if (accepted[c] || !req[c]) begin
        go = (mode == M_RR || mode == M_CLR) ? 1'b1 : rnd_bits(1);
        if (issue_left[c] > 0 && go) begin
          req[c]  <= 1'b1;
          add[c]  <= AW'(rnd_bits(4));
          wen[c]  <= rnd_bits(1);
          data[c] <= DW'(rnd_bits(DW));
          be[c]   <= BW'(rnd_bits(BW));
          issue_left[c]--;
        end else begin
          req[c] <= 1'b0;
        end
      end
      accepted[c] = 1'b0;
      if (mode == M_ROUTE) begin
        r_ready[c] <= rnd_bits(1);
      end else if (mode == M_BP) begin
        // long stretches of one r_ready level
        if (hold_cnt[c] == 0) begin
          r_ready[c]  <= rnd_bits(1);
          hold_cnt[c] = rnd_bits(4) + 2;
        end else begin
          hold_cnt[c]--;
        end
      end else begin
        r_ready[c] <= 1'b1;
      end
    end
    priority_force <= (mode == M_FORCE);
    if (mode == M_FORCE) begin
      // rotation plus optional reversal covers all six orders
      rot = rnd_bits(2) % NB_CHAN;
      rev = rnd_bits(1);
      for (int k = 0; k < NB_CHAN; k++) begin
        prio[k] <= rev ? IW'((rot + NB_CHAN - k) % NB_CHAN) : IW'((rot + k) % NB_CHAN);
      end
    end
  endtask

  function automatic logic drained();
    logic idle;
    idle = (req == '0);
    for (int c = 0; c < NB_CHAN; c++) begin
      idle = idle && (issue_left[c] == 0) && (exp_q[c].size() == 0);
    end
    return idle;
  endfunction

  task automatic run_test(input string name, input int m, input int per_chan,
                          input logic [NB_CHAN-1:0] chans);
    int err0;
    test_name = name;
    mode      = m;
    err0      = n_err;
    for (int c = 0; c < NB_CHAN; c++) begin
      issue_left[c] = chans[c] ? per_chan : 0;
      n_acc[c]      = 0;
      n_rsp[c]      = 0;
      hold_cnt[c]   = 0;
    end
    do begin
      @(posedge clk_i);
      drive();
      @(negedge clk_i);
      observe();
    end while (!drained());
    // one response per accepted request, no loss and no duplicate
    for (int c = 0; c < NB_CHAN; c++) begin
      check({name, " accepted"}, chans[c] ? per_chan : 0, n_acc[c]);
      check({name, " responses"}, n_acc[c], n_rsp[c]);
    end
    n_tests++;
    $display("test %s finished with %0d errors", name, n_err - err0);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // run limit from the request count
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("timeout: the DUT did not finish within %0d cycles", LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    rst_ni         <= 1'b0;
    clear          <= 1'b0;
    priority_force <= 1'b0;
    prio           <= '0;
    req            <= '0;
    add            <= '0;
    wen            <= '0;
    data           <= '0;
    be             <= '0;
    r_ready        <= '0;
    for (int a = 0; a < 2**AW; a++) begin
      mem_m[a]   = '0;
      known_m[a] = '0;
    end
    accepted    = '0;
    pend_q      = '0;
    after_clear = 1'b0;
    rr_cnt      = 0;
    n_chk       = 0;
    n_err       = 0;
    n_tests     = 0;
    cycles      = 0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    run_test("data_integrity", M_DATA, N_PER, '1);
    run_test("routing_by_id", M_ROUTE, N_PER, '1);
    run_test("round_robin", M_RR, N_PER, '1);
    run_test("forced_priority", M_FORCE, N_PER, '1);
    run_test("back_pressure", M_BP, N_PER, '1);
    // leave the counter off zero so the clear has something to undo
    run_test("single_channel", M_DATA, N_LONE, 3'b010);
    @(posedge clk_i);
    clear <= 1'b1;
    @(posedge clk_i);
    clear <= 1'b0;
    rr_cnt      = 0;
    after_clear = 1'b1;
    run_test("clear", M_CLR, N_CLR, '1);
    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_chk, n_err);
    if (n_err == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hdl/tcdm_pkg.sv
hdl/tcdm_fifo.sv
hdl/ooo_arbiter.sv
hdl/r_id_filter.sv
hdl/tcdm_bank.sv
hdl/tcdm_ooo_subsys.sv
bench/tcdm_ooo_asserts.sv
bench/tb_tcdm_ooo_subsys.sv
